// ==== files.f ====
hdl/spongent_pkg.sv
hdl/hash_if.sv
hdl/spi_byte_if.sv
hdl/spi_master.sv
hdl/spongent_iter.sv
hdl/autotest_feed.sv
hdl/seg_display.sv
hdl/spongent_autotest_top.sv
test/tb_clock_gen.sv
test/spongent_tb.sv

// ==== Makefile ====
# Verilator flow for the Spongent self-test.

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall -Wno-fatal
TOP        ?= spongent_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/spongent_tb.sv ====
/*
 * Testbench for the Spongent board self-test.
 * Models the SPI byte source at the pins, rebuilds the digest from the
 * seven-segment scan and compares it with a reference model of
 * Spongent-128/128/8. Prints one line per test and a closing summary.
 */

`timescale 1ns/10ps

module spongent_tb;

    localparam int REFRESH       = 4;
    localparam int DONE_TIMEOUT  = 20000;
    localparam int DIGIT_TIMEOUT = 64;
    localparam int CMP_TIMEOUT   = 16;
    localparam logic [3:0] SBOX_TBL [16] = '{
        4'hE, 4'hD, 4'hB, 4'h0, 4'h2, 4'h1, 4'h4, 4'hF,
        4'h7, 4'hA, 4'h8, 4'h5, 4'h9, 4'hC, 4'h3, 4'h6
    };

    logic        clk, rst_n, cs, sclk, mosi, miso;
    logic        sd_reset, sd_dat_1, sd_dat_2;
    logic [6:0]  seg;
    logic [7:0]  an;
    logic [1:0]  switch_i;
    logic [15:0] leds_o;

    logic [7:0]   msg_bytes [256];
    int           msg_len, seed, src_idx, bit_cnt;
    logic [7:0]   out_sh, in_sh, cmd_seen;
    bit           busy_seen, done_seen, cs_err, sticky_err, xfer_started, cmp_pending;
    bit           cs_led_err;
    logic [127:0] got_digest;
    logic [7:0]   got_len;
    int           err_cnt, tests_run, tests_failed, first_err;
    logic [31:0]  rnd_word;
    event         abort_ev;
    string        abort_why;

    tb_clock_gen #(.PERIOD_NS(8)) u_clk (.clk(clk));

    spongent_autotest_top #(.REFRESH_DIV(REFRESH)) u_dut (
        .sys_clk_pad_i (clk),
        .rst_n         (rst_n),
        .cs            (cs),
        .sclk          (sclk),
        .mosi          (mosi),
        .miso          (miso),
        .sd_reset      (sd_reset),
        .sd_dat_1      (sd_dat_1),
        .sd_dat_2      (sd_dat_2),
        .seg           (seg),
        .an            (an),
        .switch_i      (switch_i),
        .leds_o        (leds_o)
    );

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic logic [135:0] sponge_permute(input logic [135:0] s);
        logic [6:0]   lc;
        logic [135:0] t;
        logic [135:0] p;
        lc = 7'h7A;
        for (int r = 0; r < 70; r++) begin
            t = s;
            for (int k = 0; k < 7; k++) begin
                t[k]       = t[k] ^ lc[k];
                t[129 + k] = t[129 + k] ^ lc[6 - k]; // Reversed counter on top.
            end
            for (int k = 0; k < 34; k++) begin
                t[4 * k +: 4] = SBOX_TBL[t[4 * k +: 4]];
            end
            p[135] = t[135];
            for (int j = 0; j < 135; j++) begin
                p[(j * 34) % 135] = t[j];
            end
            lc = {lc[5:0], lc[6] ^ lc[5]}; // x^7 + x^6 + 1.
            s  = p;
        end
        return s;
    endfunction

    function automatic logic [127:0] spongent_ref(input int len);
        logic [135:0] st;
        logic [127:0] dg;
        st = '0;
        for (int i = 0; i < len; i++) begin
            st[7:0] = st[7:0] ^ msg_bytes[i];
            st      = sponge_permute(st);
        end
        st[7:0] = st[7:0] ^ 8'h80;
        st      = sponge_permute(st);
        dg      = {120'd0, st[7:0]};
        for (int b = 1; b < 16; b++) begin
            st = sponge_permute(st);
            dg = {dg[119:0], st[7:0]}; // First squeezed byte ends up on top.
        end
        return dg;
    endfunction

    function automatic int seg_to_nibble(input logic [6:0] s);
        case (s)
            7'h40: return 0;
            7'h79: return 1;
            7'h24: return 2;
            7'h30: return 3;
            7'h19: return 4;
            7'h12: return 5;
            7'h02: return 6;
            7'h78: return 7;
            7'h00: return 8;
            7'h10: return 9;
            7'h08: return 10;
            7'h03: return 11;
            7'h46: return 12;
            7'h21: return 13;
            7'h06: return 14;
            7'h0E: return 15;
            default: return -1;
        endcase
    endfunction

    function automatic logic [7:0] source_byte(input int idx);
        if (idx == 0) begin
            return 8'hFF; // Dummy reply while the command shifts in.
        end else if (idx == 1) begin
            return msg_len[7:0];
        end else if (idx - 2 < msg_len) begin
            return msg_bytes[idx - 2];
        end
        return 8'hFF;
    endfunction

    // ----------------------------------------------------------
    // SPI source model and monitors
    // ----------------------------------------------------------
    always @(negedge cs) begin
        src_idx = 0;
        bit_cnt = 0;
        out_sh  = source_byte(0);
        miso   <= #1 out_sh[7];
    end

    always @(posedge sclk) begin
        if (!cs) begin
            in_sh   = {in_sh[6:0], mosi};
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge sclk) begin
        if (!cs) begin
            if (bit_cnt == 8) begin
                if (src_idx == 0) begin
                    cmd_seen = in_sh;
                end
                src_idx = src_idx + 1;
                bit_cnt = 0;
                out_sh  = source_byte(src_idx);
            end else begin
                out_sh = {out_sh[6:0], 1'b1};
            end
            miso <= #1 out_sh[7];
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (!cs) begin
                xfer_started = 1'b1;
            end
            if (xfer_started && cs && !leds_o[0]) begin
                cs_err = 1'b1;
            end
            if (leds_o[2] !== !cs) begin
                cs_led_err = 1'b1;
            end
            if (leds_o[1] && !leds_o[0]) begin
                busy_seen = 1'b1;
            end
            if (done_seen && !leds_o[0]) begin
                sticky_err = 1'b1;
            end
            if (leds_o[0]) begin
                done_seen = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Checks and comparator
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("Check failed at %0t ns: %s", $time, what);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string why);
        abort_why = why;
        -> abort_ev;
        forever @(posedge clk);
    endtask

    always @(abort_ev) begin
        $display("Timeout at %0t ns: %s", $time, abort_why);
        $display("TESTS FAILED");
        $finish;
    end

    always @(posedge clk) begin
        if (cmp_pending) begin
            check_value("digest", spongent_ref(msg_len), got_digest);
            check_value("leds_o[15:8]", 128'(msg_len), 128'(got_len));
            cmp_pending = 1'b0;
        end
    end

    task automatic request_compare();
        cmp_pending = 1'b1;
        for (int cyc = 0; cyc < CMP_TIMEOUT && cmp_pending; cyc++) begin
            @(posedge clk);
        end
        #1;
        if (cmp_pending) begin
            abort_run("comparator did not take the digest");
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        busy_seen    = 1'b0;
        done_seen    = 1'b0;
        cs_err       = 1'b0;
        cs_led_err   = 1'b0;
        sticky_err   = 1'b0;
        xfer_started = 1'b0;
        cmd_seen     = 8'h00;
        check_value("cs", 128'd1, 128'(cs));
        check_value("sclk", 128'd0, 128'(sclk));
        check_value("mosi", 128'd0, 128'(mosi));
        check_value("leds_o", 128'd0, 128'(leds_o));
        check_value("an", 128'hFF, 128'(an));
        check_value("sd_reset", 128'd0, 128'(sd_reset));
        check_value("sd_dat_1", 128'd1, 128'(sd_dat_1));
        check_value("sd_dat_2", 128'd1, 128'(sd_dat_2));
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic wait_for_done();
        bit seen;
        seen = 1'b0;
        for (int cyc = 0; cyc < DONE_TIMEOUT; cyc++) begin
            @(posedge clk);
            #1;
            if (leds_o[0]) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            abort_run("done LED never came on");
        end
    endtask

    task automatic read_word(output logic [31:0] word);
        bit seen;
        int n;
        word = '0;
        repeat (8 * REFRESH + 4) @(posedge clk); // One full scan with the new word.
        #1;
        for (int i = 0; i < 8; i++) begin
            seen = 1'b0;
            for (int cyc = 0; cyc < DIGIT_TIMEOUT; cyc++) begin
                if (an[i] == 1'b0) begin
                    seen = 1'b1;
                    break;
                end
                @(posedge clk);
                #1;
            end
            if (!seen) begin
                abort_run("a digit anode never went low");
            end
            n = seg_to_nibble(seg);
            check_true(n >= 0, "segment pattern is not a hex digit");
            word[i * 4 +: 4] = n[3:0];
        end
    endtask

    task automatic read_digest();
        logic [31:0] word;
        for (int w = 0; w < 4; w++) begin
            switch_i = w[1:0];
            read_word(word);
            got_digest[w * 32 +: 32] = word;
        end
        got_len = leds_o[15:8];
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (err_cnt == first_err) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, err_cnt - first_err);
        end
        first_err = err_cnt;
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        rst_n    = 1'b0;
        miso     = 1'b1;
        switch_i = 2'd0;
        msg_len  = 0;
        seed     = 35;
        err_cnt  = 0;
        first_err = 0;
        tests_run = 0;
        tests_failed = 0;
        cmp_pending = 1'b0;

        apply_reset();
        report_test("reset state");

        wait_for_done();
        check_value("command byte", 128'h52, 128'(cmd_seen));
        check_true(!cs_err, "cs went high before done");
        check_true(!cs_led_err, "cs LED did not follow chip select");
        check_value("cs", 128'd1, 128'(cs));
        report_test("command and chip select");

        read_digest();
        request_compare();
        report_test("empty message");

        msg_len      = 1;
        msg_bytes[0] = 8'h61;
        apply_reset();
        wait_for_done();
        read_digest();
        request_compare();
        report_test("one-byte message");

        msg_len = 20;
        for (int i = 0; i < 20; i++) begin
            rnd_word     = $random(seed);
            msg_bytes[i] = rnd_word[7:0];
        end
        apply_reset();
        wait_for_done();
        read_digest();
        request_compare();
        report_test("20-byte random message");

        msg_len = 3;
        apply_reset();
        wait_for_done();
        check_true(busy_seen, "busy LED never seen before done");
        repeat (500) @(posedge clk);
        #1;
        check_true(!sticky_err && leds_o[0], "done LED dropped before reset");
        apply_reset();
        report_test("busy and done LEDs");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
/*
 * Free-running testbench clock, 8 ns period by default.
 */

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk; // Half period per toggle.

endmodule

// ==== hdl/spongent_autotest_top.sv ====
/*
 * Board top level for the Spongent hash self-test.
 * Streams a message from the SPI source through the hash core and shows
 * the digest word chosen by switch_i on the seven-segment display.
 * The unused SD-card pins are tied to fixed levels.
 */

`timescale 1ns/10ps

module spongent_autotest_top #(
    parameter int unsigned REFRESH_DIV = 100000
) (
    input  logic        sys_clk_pad_i,
    input  logic        rst_n,

    output logic        cs,
    output logic        sclk,
    output logic        mosi,
    input  logic        miso,
    output logic        sd_reset,
    output logic        sd_dat_1,
    output logic        sd_dat_2,

    output logic [6:0]  seg,
    output logic [7:0]  an,
    input  logic [1:0]  switch_i,
    output logic [15:0] leds_o
);

    logic [31:0] digest_word;

    hash_if     hif ();
    spi_byte_if sbus ();

    assign sd_reset = 1'b0;
    assign sd_dat_1 = 1'b1;
    assign sd_dat_2 = 1'b1;

    spi_master u_spi (
        .clk   (sys_clk_pad_i),
        .rst_n (rst_n),
        .bus   (sbus.shifter),
        .sclk  (sclk),
        .mosi  (mosi),
        .miso  (miso)
    );

    autotest_feed u_feed (
        .clk         (sys_clk_pad_i),
        .rst_n       (rst_n),
        .spi         (sbus.ctrl),
        .hif         (hif.feeder),
        .cs          (cs),
        .digest_word (digest_word),
        .word_sel    (switch_i),
        .status      (leds_o)
    );

    spongent_iter u_hash (
        .clk   (sys_clk_pad_i),
        .rst_n (rst_n),
        .hif   (hif.core)
    );

    seg_display #(
        .REFRESH_DIV (REFRESH_DIV)
    ) u_disp (
        .clk   (sys_clk_pad_i),
        .rst_n (rst_n),
        .din   (digest_word),
        .an    (an),
        .seg   (seg)
    );

endmodule

// ==== hdl/seg_display.sv ====
/*
 * Eight-digit multiplexed hex display for one 32-bit word.
 * Digit i shows nibble i of din on an[i]; anodes and segments are
 * active low, segments ordered g down to a.
 */

`timescale 1ns/10ps

module seg_display #(
    parameter int unsigned REFRESH_DIV = 100000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] din,
    output logic [7:0]  an,
    output logic [6:0]  seg
);

    logic [31:0] scan_cnt;
    logic [2:0]  digit;
    logic [3:0]  nibble;
    logic [6:0]  seg_dec;

    assign nibble = din[digit * 4 +: 4];

    always_comb begin
        case (nibble)
            4'h0: seg_dec = 7'h40;
            4'h1: seg_dec = 7'h79;
            4'h2: seg_dec = 7'h24;
            4'h3: seg_dec = 7'h30;
            4'h4: seg_dec = 7'h19;
            4'h5: seg_dec = 7'h12;
            4'h6: seg_dec = 7'h02;
            4'h7: seg_dec = 7'h78;
            4'h8: seg_dec = 7'h00;
            4'h9: seg_dec = 7'h10;
            4'hA: seg_dec = 7'h08;
            4'hB: seg_dec = 7'h03;
            4'hC: seg_dec = 7'h46;
            4'hD: seg_dec = 7'h21;
            4'hE: seg_dec = 7'h06;
            default: seg_dec = 7'h0E;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            digit    <= '0;
            an       <= 8'hFF;
            seg      <= 7'h7F;
        end else begin
            if (scan_cnt == REFRESH_DIV - 1) begin
                scan_cnt <= '0;
                digit    <= digit + 1'b1;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            an  <= ~(8'b1 << digit); // Registered with seg so both stay aligned.
            seg <= seg_dec;
        end
    end

endmodule

// ==== hdl/autotest_feed.sv ====
/*
 * Self-test sequencer. Reads a length byte and the message over SPI,
 * feeds each byte to the hash core, asks for the digest and latches it.
 * word_sel picks one 32-bit word of the digest for the display.
 */

`timescale 1ns/10ps

module autotest_feed (
    input  logic        clk,
    input  logic        rst_n,
    spi_byte_if.ctrl    spi,
    hash_if.feeder      hif,
    output logic        cs,
    output logic [31:0] digest_word,
    input  logic [1:0]  word_sel,
    output logic [15:0] status
);
    import spongent_pkg::*;

    logic [2:0]        fsm;
    logic [7:0]        len_q;
    logic [7:0]        remain;
    logic              done_q;
    logic [HASH_N-1:0] digest_q;
    logic              core_free;

    // busy rises one cycle after a request, so a pending pulse also counts.
    assign core_free = !hif.busy && !hif.data_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm            <= FS_START;
            cs             <= 1'b1;
            spi.start      <= 1'b0;
            spi.tx_byte    <= '0;
            hif.data       <= '0;
            hif.data_ready <= 1'b0;
            hif.start_hash <= 1'b0;
            len_q          <= '0;
            remain         <= '0;
            done_q         <= 1'b0;
            digest_q       <= '0;
        end else begin
            spi.start      <= 1'b0;
            hif.data_ready <= 1'b0;
            hif.start_hash <= 1'b0;
            case (fsm)
                FS_START: begin
                    cs          <= 1'b0;
                    spi.tx_byte <= SPI_CMD_READ;
                    spi.start   <= 1'b1;
                    fsm         <= FS_CMD;
                end
                FS_CMD: if (spi.done) begin
                    spi.tx_byte <= 8'hFF; // Idle fill while reading.
                    spi.start   <= 1'b1;
                    fsm         <= FS_LEN;
                end
                FS_LEN: if (spi.done) begin
                    len_q  <= spi.rx_byte;
                    remain <= spi.rx_byte;
                    if (spi.rx_byte == 8'd0) begin
                        fsm <= FS_FINISH;
                    end else begin
                        spi.start <= 1'b1;
                        fsm       <= FS_READ;
                    end
                end
                FS_READ: if (spi.done) begin
                    hif.data <= spi.rx_byte;
                    remain   <= remain - 1'b1;
                    fsm      <= FS_FEED;
                end
                FS_FEED: if (core_free) begin
                    hif.data_ready <= 1'b1;
                    if (remain == 8'd0) begin
                        fsm <= FS_FINISH;
                    end else begin
                        spi.start <= 1'b1; // Next read overlaps the permutation.
                        fsm       <= FS_READ;
                    end
                end
                FS_FINISH: if (core_free) begin
                    hif.start_hash <= 1'b1;
                    fsm            <= FS_WAIT;
                end
                FS_WAIT: if (hif.end_hash) begin
                    digest_q <= hif.digest;
                    cs       <= 1'b1;
                    done_q   <= 1'b1;
                    fsm      <= FS_DONE;
                end
                default: fsm <= FS_DONE; // Held until the next reset.
            endcase
        end
    end

    assign digest_word = digest_q[word_sel * 32 +: 32];

    assign status = {len_q, 5'b0, ~cs, hif.busy, done_q};

endmodule

// ==== hdl/spongent_iter.sv ====
/*
 * Iterative Spongent-128/128/8 sponge, one round per clock.
 * Each data_ready absorbs one byte and runs a 70-round permutation.
 * start_hash absorbs the pad byte, then squeezes sixteen digest bytes,
 * MSB first, and pulses end_hash after the last one.
 */

`timescale 1ns/10ps

module spongent_iter (
    input  logic   clk,
    input  logic   rst_n,
    hash_if.core   hif
);
    import spongent_pkg::*;

    sponge_state_u    state;
    sponge_state_u    with_cnt;
    sponge_state_u    subst;
    sponge_state_u    permuted;
    logic [6:0]       lc;
    logic [6:0]       lc_rev;
    logic [6:0]       lc_next;
    logic [RND_W-1:0] rnd;
    logic [BLK_W-1:0] blk;
    logic [1:0]       phase;

    // ---------------------------------------------------------
    // Round function
    // ---------------------------------------------------------
    always_comb begin
        for (int k = 0; k < 7; k++) begin
            lc_rev[k] = lc[6-k];
        end
        lc_next = {lc[5:0], ^(lc & LCNT_POLY[7:1])};
    end

    always_comb begin
        with_cnt = state;
        with_cnt.flat[6:0] = state.flat[6:0] ^ lc;
        with_cnt.flat[STATE_B-1 -: 7] = state.flat[STATE_B-1 -: 7] ^ lc_rev;
    end

    always_comb begin
        for (int i = 0; i < STATE_B / 4; i++) begin
            subst.nib[i] = SBOX[with_cnt.nib[i]];
        end
    end

    // Bit j goes to j*34 mod 135; the top bit stays put.
    always_comb begin
        permuted.flat = '0;
        for (int j = 0; j < STATE_B - 1; j++) begin
            permuted.flat[(j * (STATE_B / 4)) % (STATE_B - 1)] = subst.flat[j];
        end
        permuted.flat[STATE_B-1] = subst.flat[STATE_B-1];
    end

    // ---------------------------------------------------------
    // Sponge sequencing
    // ---------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state.flat   <= '0;
            lc           <= LCNT_INIT;
            rnd          <= '0;
            blk          <= '0;
            phase        <= PH_ABSORB;
            hif.busy     <= 1'b0;
            hif.end_hash <= 1'b0;
            hif.digest   <= '0;
        end else begin
            hif.end_hash <= 1'b0;
            if (!hif.busy) begin
                if (hif.data_ready) begin
                    state.flat[HASH_R-1:0] <= state.flat[HASH_R-1:0] ^ hif.data;
                    hif.busy <= 1'b1;
                    phase    <= PH_ABSORB;
                    rnd      <= '0;
                    lc       <= LCNT_INIT;
                end else if (hif.start_hash) begin
                    state.flat[HASH_R-1:0] <= state.flat[HASH_R-1:0] ^ PAD_BYTE;
                    hif.busy <= 1'b1;
                    phase    <= PH_PAD;
                    rnd      <= '0;
                    blk      <= '0;
                    lc       <= LCNT_INIT;
                end
            end else begin
                state <= permuted;
                lc    <= lc_next;
                rnd   <= rnd + 1'b1;
                if (rnd == RND_W'(ROUNDS - 1)) begin
                    rnd <= '0;
                    lc  <= LCNT_INIT;
                    case (phase)
                        PH_PAD, PH_SQUEEZE: begin
                            // Rate byte of the finished permutation.
                            hif.digest <= {hif.digest[HASH_N-HASH_R-1:0],
                                           permuted.flat[HASH_R-1:0]};
                            if (blk == BLK_W'(SQUEEZE_BLOCKS - 1)) begin
                                hif.busy     <= 1'b0;
                                hif.end_hash <= 1'b1;
                            end else begin
                                blk   <= blk + 1'b1;
                                phase <= PH_SQUEEZE;
                            end
                        end
                        default: hif.busy <= 1'b0; // Byte absorbed.
                    endcase
                end
            end
        end
    end

endmodule

// ==== hdl/spi_master.sv ====
/*
 * Mode-0 SPI byte shifter, MSB first.
 * sclk idles low and toggles every SPI_DIV clocks, so one byte takes
 * 32 clocks. mosi moves on falling edges and miso is sampled on rising
 * edges. Chip select is left to the caller.
 */

`timescale 1ns/10ps

module spi_master (
    input  logic         clk,
    input  logic         rst_n,
    spi_byte_if.shifter  bus,
    output logic         sclk,
    output logic         mosi,
    input  logic         miso
);
    import spongent_pkg::*;

    logic                 active;
    logic [SPI_DIV_W-1:0] div_cnt;
    logic [3:0]           half_cnt;
    logic [7:0]           tx_sh;
    logic [7:0]           rx_sh;

    assign bus.rx_byte = rx_sh;
    assign mosi        = tx_sh[7];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            div_cnt  <= '0;
            half_cnt <= '0;
            tx_sh    <= '0;
            rx_sh    <= '0;
            sclk     <= 1'b0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (!active) begin
                if (bus.start) begin
                    active   <= 1'b1;
                    div_cnt  <= '0;
                    half_cnt <= '0;
                    tx_sh    <= bus.tx_byte; // First bit is on mosi before the first rise.
                end
            end else if (div_cnt == SPI_DIV_W'(SPI_DIV - 1)) begin
                div_cnt  <= '0;
                sclk     <= ~sclk;
                half_cnt <= half_cnt + 1'b1;
                if (!sclk) begin
                    rx_sh <= {rx_sh[6:0], miso};
                end else begin
                    tx_sh <= {tx_sh[6:0], 1'b0};
                    if (half_cnt == 4'd15) begin // Eighth falling edge ends the byte.
                        active   <= 1'b0;
                        bus.done <= 1'b1;
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/spi_byte_if.sv ====
/*
 * Byte-level handshake between the feeder and the SPI master.
 * A start pulse launches one byte; done flags the received byte.
 */

`timescale 1ns/10ps

interface spi_byte_if;

    logic       start;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    logic       done;

    modport ctrl (output start, tx_byte, input rx_byte, done);

    modport shifter (input start, tx_byte, output rx_byte, done);

endinterface

// ==== hdl/hash_if.sv ====
/*
 * Link between the message feeder and the Spongent core.
 * The feeder pulses data_ready per byte and start_hash once at the end;
 * the core answers with busy, a one-cycle end_hash and the digest.
 */

`timescale 1ns/10ps

interface hash_if;
    import spongent_pkg::*;

    logic [HASH_R-1:0] data;
    logic              data_ready;
    logic              start_hash;
    logic              busy;
    logic              end_hash;
    logic [HASH_N-1:0] digest;

    modport feeder (
        output data, data_ready, start_hash,
        input  busy, end_hash, digest
    );

    modport core (
        input  data, data_ready, start_hash,
        output busy, end_hash, digest
    );

endinterface

// ==== hdl/spongent_pkg.sv ====
/*
 * Shared constants and types for the Spongent-128/128/8 board self-test.
 * Holds the hash parameters, the S-box, the sponge state view, the SPI
 * framing constants and the state encodings of the core and the feeder.
 * Modules import it inside their body.
 */

package spongent_pkg;

    // ---------------------------------------------------------
    // Spongent-128/128/8 parameters
    // ---------------------------------------------------------
    localparam int HASH_N         = 128;
    localparam int HASH_C         = 128;
    localparam int HASH_R         = 8;
    localparam int STATE_B        = HASH_C + HASH_R;
    localparam int ROUNDS         = 70;
    localparam int SQUEEZE_BLOCKS = HASH_N / HASH_R;
    localparam int RND_W          = $clog2(ROUNDS);
    localparam int BLK_W          = $clog2(SQUEEZE_BLOCKS);

    localparam logic [6:0] LCNT_INIT = 7'h7A;
    localparam logic [7:0] LCNT_POLY = 8'hC1; // x^7 + x^6 + 1.

    // Entry i is S(i).
    localparam logic [15:0][3:0] SBOX = {
        4'h6, 4'h3, 4'hC, 4'h9, 4'h5, 4'h8, 4'hA, 4'h7,
        4'hF, 4'h4, 4'h1, 4'h2, 4'h0, 4'hB, 4'hD, 4'hE
    };

    // The permutation layer works on bits, the S-box layer on nibbles.
    typedef union packed {
        logic [STATE_B-1:0]         flat;
        logic [STATE_B/4-1:0][3:0]  nib;
    } sponge_state_u;

    localparam logic [7:0] PAD_BYTE = 8'h80;

    // ---------------------------------------------------------
    // SPI source framing
    // ---------------------------------------------------------
    localparam logic [7:0] SPI_CMD_READ = 8'h52;
    localparam int         SPI_DIV      = 2;
    localparam int         SPI_DIV_W    = $clog2(SPI_DIV + 1);

    // Sponge phases.
    localparam logic [1:0] PH_ABSORB  = 2'd0;
    localparam logic [1:0] PH_PAD     = 2'd1;
    localparam logic [1:0] PH_SQUEEZE = 2'd2;

    // Feeder FSM states.
    localparam logic [2:0] FS_START  = 3'd0;
    localparam logic [2:0] FS_CMD    = 3'd1;
    localparam logic [2:0] FS_LEN    = 3'd2;
    localparam logic [2:0] FS_READ   = 3'd3;
    localparam logic [2:0] FS_FEED   = 3'd4;
    localparam logic [2:0] FS_FINISH = 3'd5;
    localparam logic [2:0] FS_WAIT   = 3'd6;
    localparam logic [2:0] FS_DONE   = 3'd7;

endpackage
